//--- project.f
+incdir+rtl
rtl/ucode_pkg.sv
rtl/ucode_if.sv
rtl/ucode_rom.sv
rtl/ucode_fetch.sv
rtl/ucode_exec.sv
rtl/wb_master.sv
rtl/bus_tester_top.sv
tb/wb_mem_model.sv
tb/tb_bus_tester.sv

//--- Makefile
# Verilator build and run of the bus tester testbench

TOP = tb_bus_tester
LOG = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test    build with Verilator, run the testbench and check $(LOG)"
	@echo "  clean   remove the build directory and the log"
	@echo "  help    show this list"

test:
	verilator --binary --timing --assert -Wno-fatal -f project.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee $(LOG)
	@if grep -q "Testbench failed" $(LOG); then exit 1; fi
	@grep -q "Testbench passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

//--- tb/tb_bus_tester.sv
// testbench for the microcoded bus tester
// idle, zero wait, random wait and read corruption tests

`include "ucode_consts.svh"

module tb_bus_tester;
   timeunit 1ns;
   timeprecision 100ps;

   localparam int max_wait = 7;
   localparam int timeout_cycles = 4 * `BLOCK_LEN * 2 * (3 + max_wait) * 2;

   logic                   clk;
   logic                   reset;
   logic                   start;
   logic                   done;
   logic                   fault;
   logic [`UC_ADDR_W-1:0]  pc;
   logic                   wb_cyc;
   logic                   wb_stb;
   logic                   wb_we;
   logic [`BUS_ADDR_W-1:0] wb_adr;
   logic [`BUS_DATA_W-1:0] wb_wdat;
   logic [`BUS_DATA_W-1:0] wb_rdat;
   logic                   wb_ack;
   logic [2:0]             waits = 3'd0;
   logic                   rand_waits;
   logic                   corrupt_en;
   logic [15:0]            corrupt_idx;
   logic [4:0]             corrupt_bit;
   logic [15:0]            write_count;
   logic [15:0]            read_count;
   logic                   stable_err;
   int                     seed = 27;
   int                     errors = 0;
   int                     tests = 0;
   int                     failed_tests = 0;
   int                     cycles = 0;

   bus_tester_top uut (
      .clk      (clk),
      .reset    (reset),
      .start    (start),
      .done     (done),
      .fault    (fault),
      .pc       (pc),
      .wb_cyc   (wb_cyc),
      .wb_stb   (wb_stb),
      .wb_we    (wb_we),
      .wb_adr   (wb_adr),
      .wb_dat_o (wb_wdat),
      .wb_dat_i (wb_rdat),
      .wb_ack   (wb_ack)
   );

   wb_mem_model u_mem (
      .clk         (clk),
      .reset       (reset),
      .wb_cyc      (wb_cyc),
      .wb_stb      (wb_stb),
      .wb_we       (wb_we),
      .wb_adr      (wb_adr),
      .wdat        (wb_wdat),
      .rdat        (wb_rdat),
      .wb_ack      (wb_ack),
      .waits       (waits),
      .corrupt_en  (corrupt_en),
      .corrupt_idx (corrupt_idx),
      .corrupt_bit (corrupt_bit),
      .write_count (write_count),
      .read_count  (read_count),
      .stable_err  (stable_err)
   );

   always #50 clk = ~clk;

   always @(negedge clk)
      waits <= rand_waits ? 3'($random(seed)) : 3'd0;   // model latches it per access

   always @(posedge clk)
   begin
      cycles++;
      if (cycles >= timeout_cycles)
      begin
         $display("timeout after %0d cycles, the tester never raised done or fault", cycles);
         $display("Testbench failed");
         $finish;
      end
   end

   task automatic check_value(input string name, input logic [31:0] actual,
                              input logic [31:0] expected);
      if (actual !== expected)
      begin
         $display("mismatch %s: got %h, expected %h", name, actual, expected);
         errors++;
      end
   endtask

   task automatic report_test(input string name, input int errors_before);
      tests++;
      if (errors == errors_before)
         $display("test %s: ok", name);
      else
      begin
         failed_tests++;
         $display("test %s: %0d errors", name, errors - errors_before);
      end
   endtask

   task automatic reset_dut();
      @(negedge clk);
      reset = 1'b1;
      start = 1'b0;
      repeat (4) @(negedge clk);
      reset = 1'b0;
   endtask

   task automatic wait_for_end();
      do
         @(negedge clk);
      while (!done && !fault);
   endtask

   // each block word holds the low address byte in all four bytes
   task automatic check_block();
      logic [`BUS_ADDR_W-1:0] adr;
      for (int i = 0; i < `BLOCK_LEN; i++)
      begin
         adr = `BLOCK_BASE + 22'(i);
         check_value($sformatf("mem[%h]", adr), u_mem.store[adr[9:0]], {4{adr[7:0]}});
      end
   endtask

   task automatic idle_test();
      int                    errors_before;
      logic [`UC_ADDR_W-1:0] pc0;
      logic                  bus_seen;
      errors_before = errors;
      rand_waits = 1'b0;
      corrupt_en = 1'b0;
      reset_dut();
      check_value("done", done, 1'b0);
      check_value("fault", fault, 1'b0);
      check_value("wb_cyc", wb_cyc, 1'b0);
      check_value("wb_stb", wb_stb, 1'b0);
      pc0 = pc;
      bus_seen = 1'b0;
      repeat (20)
      begin
         @(negedge clk);
         bus_seen = bus_seen | wb_cyc | wb_stb;
         check_value("pc", pc, pc0);
      end
      check_value("wb_cyc", bus_seen, 1'b0);
      report_test("idle", errors_before);
   endtask

   task automatic full_run_test(input string name, input logic random_mode);
      int errors_before;
      errors_before = errors;
      rand_waits = random_mode;
      corrupt_en = 1'b0;
      reset_dut();
      start = 1'b1;
      wait_for_end();
      check_value("done", done, 1'b1);
      check_value("fault", fault, 1'b0);
      check_value("write_count", write_count, `BLOCK_LEN);
      check_value("read_count", read_count, `BLOCK_LEN);
      check_value("stable_err", stable_err, 1'b0);
      check_block();
      report_test(name, errors_before);
   endtask

   task automatic corrupt_test();
      int                    errors_before;
      int                    k;
      logic [`UC_ADDR_W-1:0] pc_hold;
      errors_before = errors;
      k = `BLOCK_LEN / 2 + 5;
      rand_waits = 1'b1;
      corrupt_idx = 16'(k);
      corrupt_bit = 5'd13;
      corrupt_en = 1'b1;
      reset_dut();
      start = 1'b1;
      wait_for_end();
      check_value("fault", fault, 1'b1);
      check_value("done", done, 1'b0);
      check_value("read_count", read_count, k + 1);
      pc_hold = pc;
      repeat (10)
      begin
         @(negedge clk);
         check_value("pc", pc, pc_hold);   // frozen on the fault word
      end
      corrupt_en = 1'b0;
      report_test("corruption", errors_before);
   endtask

   initial
   begin
      clk = 1'b0;
      reset = 1'b1;
      start = 1'b0;
      rand_waits = 1'b0;
      corrupt_en = 1'b0;
      corrupt_idx = 16'd0;
      corrupt_bit = 5'd0;
      idle_test();
      full_run_test("zero_wait", 1'b0);
      full_run_test("random_wait", 1'b1);
      corrupt_test();
      $display("%0d tests, %0d passed, %0d failed, %0d errors",
               tests, tests - failed_tests, failed_tests, errors);
      if (errors == 0)
         $display("Testbench passed");
      else
         $display("Testbench failed");
      $finish;
   end

endmodule

//--- tb/wb_mem_model.sv
// wishbone classic slave memory with wait states per access,
// one injectable read corruption, access counters and a hold check

`include "ucode_consts.svh"

module wb_mem_model (
   input  logic                   clk,
   input  logic                   reset,
   input  logic                   wb_cyc,
   input  logic                   wb_stb,
   input  logic                   wb_we,
   input  logic [`BUS_ADDR_W-1:0] wb_adr,
   input  logic [`BUS_DATA_W-1:0] wdat,
   output logic [`BUS_DATA_W-1:0] rdat,
   output logic                   wb_ack,
   input  logic [2:0]             waits,
   input  logic                   corrupt_en,
   input  logic [15:0]            corrupt_idx,
   input  logic [4:0]             corrupt_bit,
   output logic [15:0]            write_count,
   output logic [15:0]            read_count,
   output logic                   stable_err
);
   timeunit 1ns;
   timeprecision 100ps;

   logic [`BUS_DATA_W-1:0] store [0:1023];
   logic                   active;
   logic [2:0]             lim;
   logic [2:0]             cnt;
   logic [`BUS_ADDR_W-1:0] held_adr;
   logic                   held_we;
   logic [`BUS_DATA_W-1:0] held_dat;
   logic                   corrupt_now;

   assign corrupt_now = corrupt_en && !wb_we && read_count == corrupt_idx;
   assign rdat = store[wb_adr[9:0]] ^ (corrupt_now ? (32'h1 << corrupt_bit) : 32'h0);

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         wb_ack <= 1'b0;
         active <= 1'b0;
         cnt <= 3'd0;
         lim <= 3'd0;
         write_count <= 16'd0;
         read_count <= 16'd0;
         for (int i = 0; i < 1024; i++)
            store[i] <= 32'hbad00000 | 32'(i);   // depends on whole index
      end
      else if (wb_ack)
      begin
         wb_ack <= 1'b0;
         active <= 1'b0;
         if (wb_we)
         begin
            store[wb_adr[9:0]] <= wdat;
            write_count <= write_count + 16'd1;
         end
         else
            read_count <= read_count + 16'd1;
      end
      else if (wb_cyc && wb_stb)
      begin
         if (!active)
         begin
            active <= 1'b1;   // new access, latch its wait count
            lim <= waits;
            cnt <= 3'd1;
            held_adr <= wb_adr;
            held_we <= wb_we;
            held_dat <= wdat;
            wb_ack <= waits == 3'd0;
         end
         else if (cnt == lim)
            wb_ack <= 1'b1;
         else
            cnt <= cnt + 3'd1;
      end
   end

   always_ff @(posedge clk)
   begin
      if (reset)
         stable_err <= 1'b0;
      else if (active && wb_stb &&
               (wb_adr != held_adr || wb_we != held_we || (wb_we && wdat != held_dat)))
         stable_err <= 1'b1;   // sticky
   end

endmodule

//--- rtl/bus_tester_top.sv
// microcoded bus tester: fetch, execute and wishbone master
// with plain wishbone ports

`include "ucode_consts.svh"

module bus_tester_top (
   input  logic                   clk,
   input  logic                   reset,
   input  logic                   start,
   output logic                   done,
   output logic                   fault,
   output logic [`UC_ADDR_W-1:0]  pc,
   output logic                   wb_cyc,
   output logic                   wb_stb,
   output logic                   wb_we,
   output logic [`BUS_ADDR_W-1:0] wb_adr,
   output logic [`BUS_DATA_W-1:0] wb_dat_o,
   input  logic [`BUS_DATA_W-1:0] wb_dat_i,
   input  logic                   wb_ack
);

   uinst_if   uc ();
   bus_req_if bus ();

   assign pc = uc.upc;

   ucode_fetch u_fetch (
      .clk   (clk),
      .reset (reset),
      .start (start),
      .uc    (uc)
   );

   ucode_exec u_exec (
      .clk   (clk),
      .reset (reset),
      .start (start),
      .uc    (uc),
      .bus   (bus),
      .done  (done),
      .fault (fault)
   );

   wb_master u_wb (
      .clk      (clk),
      .reset    (reset),
      .bus      (bus),
      .wb_cyc   (wb_cyc),
      .wb_stb   (wb_stb),
      .wb_we    (wb_we),
      .wb_adr   (wb_adr),
      .wb_dat_o (wb_dat_o),
      .wb_dat_i (wb_dat_i),
      .wb_ack   (wb_ack)
   );

endmodule

//--- rtl/wb_master.sv
// wishbone classic master, one read or write cycle per request

`include "ucode_consts.svh"

module wb_master (
   input  logic                   clk,
   input  logic                   reset,
   bus_req_if.master              bus,
   output logic                   wb_cyc,
   output logic                   wb_stb,
   output logic                   wb_we,
   output logic [`BUS_ADDR_W-1:0] wb_adr,
   output logic [`BUS_DATA_W-1:0] wb_dat_o,
   input  logic [`BUS_DATA_W-1:0] wb_dat_i,
   input  logic                   wb_ack
);

   typedef enum logic {st_idle, st_cycle} state_e;

   state_e state;
   logic   ack_q;   // request still high from the finished cycle
   logic   we_q;
   logic   launch;

   assign launch = state == st_idle && bus.req && !ack_q;

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         state <= st_idle;
         ack_q <= 1'b0;
      end
      else
      begin
         ack_q <= bus.ack_done;
         case (state)
            st_idle:  if (launch) state <= st_cycle;
            st_cycle: if (wb_ack) state <= st_idle;
            default:  state <= st_idle;
         endcase
      end
   end

   always_ff @(posedge clk)
   begin
      if (launch)
      begin
         wb_adr <= bus.adr;
         wb_dat_o <= bus.wdat;
         we_q <= bus.we;
      end
   end

   assign wb_cyc = state == st_cycle;
   assign wb_stb = state == st_cycle;
   assign wb_we = wb_cyc & we_q;

   assign bus.ack_done = wb_cyc & wb_ack;
   assign bus.rdat = wb_dat_i;

   a_stable_while_wait: assert property (@(posedge clk) disable iff (reset)
      wb_stb && !wb_ack |=> wb_stb && $stable(wb_adr) && $stable(wb_we));
   a_stb_in_cyc: assert property (@(posedge clk) disable iff (reset) wb_stb |-> wb_cyc);

endmodule

//--- rtl/ucode_exec.sv
// execute stage: a, b and d registers, alu, pattern generator,
// branch and stall decision, done and fault flags

`include "ucode_consts.svh"

module ucode_exec (
   input  logic     clk,
   input  logic     reset,
   input  logic     start,
   uinst_if.exec    uc,
   bus_req_if.exec  bus,
   output logic     done,
   output logic     fault
);
   import ucode_pkg::*;

   uword_t                 uw;
   logic [`BUS_ADDR_W-1:0] a;
   logic [`BUS_DATA_W-1:0] b;
   logic [`BUS_DATA_W-1:0] d;
   logic [`BUS_DATA_W-1:0] pat;
   logic [`BUS_DATA_W-1:0] src;
   logic [`BUS_DATA_W-1:0] dst;
   logic [`BUS_DATA_W-1:0] sum;
   logic                   is_bus;
   logic                   bus_fin;   // ack seen while held by start
   logic                   halt;
   logic                   take;

   assign uw = uc.uword;
   assign pat = {4{a[7:0]}};
   assign sum = src + uw.imm;

   always_comb
   begin
      case (uw.src)
         reg_a:   src = {{(`BUS_DATA_W-`BUS_ADDR_W){1'b0}}, a};
         reg_b:   src = b;
         reg_d:   src = d;
         reg_imm: src = uw.imm;
         reg_pat: src = pat;
         default: src = '0;
      endcase
   end

   always_comb
   begin
      case (uw.dst)
         reg_a:   dst = {{(`BUS_DATA_W-`BUS_ADDR_W){1'b0}}, a};
         reg_b:   dst = b;
         reg_d:   dst = d;
         default: dst = '0;
      endcase
   end

   always_comb
   begin
      case (uw.op)
         op_tst:  take = ~|(dst & src);
         op_cmp:  take = dst == src;
         op_jmp:  take = 1'b1;
         default: take = 1'b0;
      endcase
   end

   assign is_bus = uw.op == op_write || uw.op == op_read;
   assign halt = done | fault | uw.op == op_done | uw.op == op_fault;

   assign uc.stall = ~start | (is_bus & ~bus.ack_done & ~bus_fin) | halt;
   assign uc.redirect = take & ~uc.stall;
   assign uc.target = uw.next;

   assign bus.req = is_bus & ~bus_fin;
   assign bus.we = uw.op == op_write;
   assign bus.adr = a;
   assign bus.wdat = d;

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         a <= '0;
         b <= '0;
      end
      else if (!uc.stall && uw.op == op_add)
         case (uw.dst)
            reg_a:   a <= sum[`BUS_ADDR_W-1:0];
            reg_b:   b <= sum;
            default: ;
         endcase
   end

   always_ff @(posedge clk)
   begin
      if (reset)
         d <= '0;
      else if (bus.ack_done && uw.op == op_read)
         d <= bus.rdat;
      else if (!uc.stall && uw.op == op_add && uw.dst == reg_d)
         d <= sum;
   end

   always_ff @(posedge clk)
   begin
      if (reset)
         bus_fin <= 1'b0;
      else if (!uc.stall)
         bus_fin <= 1'b0;
      else if (bus.ack_done)
         bus_fin <= 1'b1;
   end

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         done <= 1'b0;
         fault <= 1'b0;
      end
      else if (start)
      begin
         if (uw.op == op_done)
            done <= 1'b1;
         if (uw.op == op_fault)
            fault <= 1'b1;   // pc stays on the fault word
      end
   end

   // request held until the master reports completion
   a_req_until_ack: assert property (@(posedge clk) disable iff (reset)
      bus.req && !bus.ack_done |=> bus.req);

endmodule

//--- rtl/ucode_fetch.sv
// fetch stage: microcode address register, next address select
// and the microprogram rom

`include "ucode_consts.svh"

module ucode_fetch (
   input logic    clk,
   input logic    reset,
   input logic    start,
   uinst_if.fetch uc
);

   logic [`UC_ADDR_W-1:0] pc;
   logic [`UC_ADDR_W-1:0] npc;
   logic [`UC_ADDR_W-1:0] rom_addr;
   logic                  hold;

   assign hold = uc.stall | ~start;
   assign npc = uc.redirect ? {{(`UC_ADDR_W-`UC_NEXT_W){1'b0}}, uc.target} : pc + 1'b1;
   assign rom_addr = hold ? pc : npc;   // re-read current word while held

   always_ff @(posedge clk)
   begin
      if (reset)
         pc <= '1;   // first fetch after reset reads 0
      else if (!hold)
         pc <= npc;
   end

   assign uc.upc = pc;

   ucode_rom u_rom (
      .clk   (clk),
      .reset (reset),
      .addr  (rom_addr),
      .uword (uc.uword)
   );

   // execute must never branch out of a stalled word
   a_no_redirect_in_stall: assert property (@(posedge clk) disable iff (reset)
      !(uc.redirect && uc.stall));

endmodule

//--- rtl/ucode_rom.sv
// microprogram rom, one cycle from address to word
// fill pass, compare pass, done

`include "ucode_consts.svh"

module ucode_rom (
   input  logic                  clk,
   input  logic                  reset,
   input  logic [`UC_ADDR_W-1:0] addr,
   output ucode_pkg::uword_t     uword
);
   import ucode_pkg::*;

   function automatic uword_t uw(uc_op_e op, uc_reg_e dst, uc_reg_e src,
                                 logic [`UC_NEXT_W-1:0] nxt,
                                 logic [`BUS_DATA_W-1:0] imm);
      return '{op, dst, src, nxt, imm};
   endfunction

   always_ff @(posedge clk)
   begin
      if (reset)
         uword <= '0;   // nop
      else
         case (addr)
            // fill
            8'h00: uword <= uw(op_add, reg_a, reg_none, 6'h00, 32'(`BLOCK_BASE));
            8'h01: uword <= uw(op_add, reg_b, reg_none, 6'h00, 32'h0);
            8'h02: uword <= uw(op_add, reg_d, reg_pat, 6'h00, 32'h0);   // d = pat
            8'h03: uword <= uw(op_write, reg_none, reg_none, 6'h00, 32'h0);
            8'h04: uword <= uw(op_add, reg_a, reg_a, 6'h00, 32'h1);
            8'h05: uword <= uw(op_add, reg_b, reg_b, 6'h00, 32'h1);
            8'h06: uword <= uw(op_cmp, reg_b, reg_imm, 6'h08, 32'(`BLOCK_LEN));
            8'h07: uword <= uw(op_jmp, reg_none, reg_none, 6'h02, 32'h0);
            // compare
            8'h08: uword <= uw(op_add, reg_a, reg_none, 6'h00, 32'(`BLOCK_BASE));
            8'h09: uword <= uw(op_add, reg_b, reg_none, 6'h00, 32'h0);
            8'h0a: uword <= uw(op_read, reg_none, reg_none, 6'h00, 32'h0);
            8'h0b: uword <= uw(op_cmp, reg_d, reg_pat, 6'h0d, 32'h0);   // match skips fault
            8'h0c: uword <= uw(op_fault, reg_none, reg_none, 6'h00, 32'h0);
            8'h0d: uword <= uw(op_add, reg_a, reg_a, 6'h00, 32'h1);
            8'h0e: uword <= uw(op_add, reg_b, reg_b, 6'h00, 32'h1);
            8'h0f: uword <= uw(op_cmp, reg_b, reg_imm, 6'h11, 32'(`BLOCK_LEN));
            8'h10: uword <= uw(op_jmp, reg_none, reg_none, 6'h0a, 32'h0);
            8'h11: uword <= uw(op_done, reg_none, reg_none, 6'h00, 32'h0);
            default: uword <= uw(op_jmp, reg_none, reg_none, 6'h00, 32'h0);
         endcase
   end

endmodule

//--- rtl/ucode_if.sv
// uinst_if between fetch and execute
// bus_req_if between execute and the wishbone master

`include "ucode_consts.svh"

interface uinst_if;
   import ucode_pkg::*;

   uword_t                uword;
   logic [`UC_ADDR_W-1:0] upc;
   logic                  stall;
   logic                  redirect;
   logic [`UC_NEXT_W-1:0] target;

   modport fetch (output uword, output upc, input stall, input redirect, input target);
   modport exec (input uword, output stall, output redirect, output target);
endinterface

interface bus_req_if;
   logic                   req;
   logic                   we;
   logic [`BUS_ADDR_W-1:0] adr;
   logic [`BUS_DATA_W-1:0] wdat;
   logic                   ack_done;   // one cycle, rdat valid
   logic [`BUS_DATA_W-1:0] rdat;

   modport exec (output req, output we, output adr, output wdat, input ack_done, input rdat);
   modport master (input req, input we, input adr, input wdat, output ack_done, output rdat);
endinterface

//--- rtl/ucode_pkg.sv
// microcode opcodes, register selects and the microword layout

`include "ucode_consts.svh"

package ucode_pkg;

   typedef enum logic [3:0] {
      op_nop   = 4'd0,
      op_write = 4'd1,   // m[a] <= d
      op_read  = 4'd2,   // d <= m[a]
      op_add   = 4'd3,   // dst <= src + imm
      op_tst   = 4'd5,   // branch if (dst & src) == 0
      op_cmp   = 4'd6,   // branch if dst == src
      op_jmp   = 4'd7,
      op_done  = 4'd8,
      op_fault = 4'd15
   } uc_op_e;

   typedef enum logic [2:0] {
      reg_none = 3'd0,
      reg_a    = 3'd1,   // bus address
      reg_b    = 3'd2,   // word count
      reg_d    = 3'd4,   // data
      reg_imm  = 3'd5,
      reg_pat  = 3'd7    // pattern generator
   } uc_reg_e;

   typedef struct packed {
      uc_op_e                 op;
      uc_reg_e                dst;
      uc_reg_e                src;
      logic [`UC_NEXT_W-1:0]  next;
      logic [`BUS_DATA_W-1:0] imm;
   } uword_t;

endpackage

//--- rtl/ucode_consts.svh
// widths of the microcode and Wishbone buses
// location and size of the test block

`ifndef UCODE_CONSTS_SVH
`define UCODE_CONSTS_SVH

// microcode address and branch target field
`define UC_ADDR_W 8
`define UC_NEXT_W 6

// wishbone word address and data
`define BUS_ADDR_W 22
`define BUS_DATA_W 32

// test block
`define BLOCK_BASE 22'h11000
`define BLOCK_LEN 64

`endif
